/* run.sh */
#!/bin/sh
# Build the DUT and testbench with Verilator, run, and look for the pass line
verilator --binary --timing -j 0 --top-module mem_wb_tb -f sources.f -o mem_wb_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/mem_wb_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* sources.f */
+incdir+src
src/ctrl_pkg.sv
src/data_pkg.sv
src/data_mem.sv
src/ex_mem_reg.sv
src/mem_access.sv
src/mem_wb_reg.sv
src/writeback_sel.sv
src/mem_wb_top.sv
verif/mem_wb_tb.sv

/* src/ctrl_pkg.sv */
/*
 * Control field types
 * Register numbers, load/store funct3 and the access size code
 */
`include "pipe_defs.svh"

package ctrl_pkg;

    // Destination register number
    typedef logic [`PIPE_NB_REG-1:0] reg_addr_t;

    // Load/store funct3, bit 2 unsigned, bits 1:0 size
    typedef logic [2:0] func3_t;

    // Access size, same coding as funct3 bits 1:0
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

endpackage

/* src/data_mem.sv */
/*
 * Data RAM
 * Byte-writable words, synchronous write, registered read
 * that holds while no read is requested
 */
`timescale 1ns/100ps
`include "pipe_defs.svh"

module data_mem (
    input  logic                             clk,
    input  logic                             i_we,
    input  logic                             i_re,
    input  logic [`PIPE_DMEM_WORDS_LOG2-1:0] i_addr,   // Word index
    input  data_pkg::byte_en_t               i_be,
    input  data_pkg::word_t                  i_wdata,
    output data_pkg::word_t                  o_rdata
);

    import data_pkg::*;

    word_t mem [2**`PIPE_DMEM_WORDS_LOG2];

    // Write only the strobed lanes
    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int i = 0; i < $bits(byte_en_t); i++) begin
                if (i_be[i]) begin
                    mem[i_addr][8*i +: 8] <= i_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

/* src/data_pkg.sv */
/*
 * Datapath types
 * Data word, instruction address and byte lane strobes
 */
`include "pipe_defs.svh"

package data_pkg;

    typedef logic [`PIPE_DATA_WIDTH-1:0] word_t;
    typedef logic [`PIPE_NB_PC-1:0] pc_t;

    // One strobe per byte of a word
    typedef logic [`PIPE_DATA_WIDTH/8-1:0] byte_en_t;

endpackage

/* src/ex_mem_reg.sv */
/*
 * EX/MEM pipeline register
 * Holds one instruction between execute and the memory stage.
 * Flush makes a bubble, enable low holds the slot
 */
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_en,
    input  logic                i_flush,
    input  logic                i_reg_write,
    input  logic                i_mem_read,
    input  logic                i_mem_write,
    input  logic                i_mem_to_reg,
    input  logic                i_branch,
    input  logic                i_jump,
    input  logic                i_link_reg,
    input  ctrl_pkg::mem_size_t i_data_size,
    input  ctrl_pkg::func3_t    i_func3,
    input  ctrl_pkg::reg_addr_t i_rd_addr,
    input  data_pkg::pc_t       i_pc_next,     // PC+4
    input  data_pkg::pc_t       i_branch_addr,
    input  data_pkg::word_t     i_alu,
    input  data_pkg::word_t     i_data2,       // Store data
    output logic                o_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mem_to_reg,
    output logic                o_branch,
    output logic                o_jump,
    output logic                o_link_reg,
    output ctrl_pkg::mem_size_t o_data_size,
    output ctrl_pkg::func3_t    o_func3,
    output ctrl_pkg::reg_addr_t o_rd_addr,
    output data_pkg::pc_t       o_pc_next,
    output data_pkg::pc_t       o_branch_addr,
    output data_pkg::word_t     o_alu,
    output data_pkg::word_t     o_data2
);

    // Control fields, cleared by reset and by flush
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            o_reg_write  <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_branch     <= 1'b0;
            o_jump       <= 1'b0;
            o_link_reg   <= 1'b0;
            o_data_size  <= '0;
            o_func3      <= '0;
        end else if (i_en) begin
            o_reg_write  <= i_reg_write;
            o_mem_read   <= i_mem_read;
            o_mem_write  <= i_mem_write;
            o_mem_to_reg <= i_mem_to_reg;
            o_branch     <= i_branch;
            o_jump       <= i_jump;
            o_link_reg   <= i_link_reg;
            o_data_size  <= i_data_size;
            o_func3      <= i_func3;
        end
    end

    // Payload fields
    always_ff @(posedge clk) begin
        if (i_flush) begin
            o_rd_addr     <= '0;
            o_pc_next     <= '0;
            o_branch_addr <= '0;
            o_alu         <= '0;
            o_data2       <= '0;
        end else if (i_en) begin
            o_rd_addr     <= i_rd_addr;
            o_pc_next     <= i_pc_next;
            o_branch_addr <= i_branch_addr;
            o_alu         <= i_alu;
            o_data2       <= i_data2;
        end
    end

    // A captured instruction is a load or a store, never both
    a_no_load_store: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_en && !i_flush |=> !(o_mem_read && o_mem_write))
        else $error("ex_mem_reg: load and store set in one slot");

endmodule

/* src/mem_access.sv */
/*
 * Memory stage
 * Builds byte strobes and lane-aligned store data, drives the data RAM
 * and turns branches and jumps into a redirect
 */
`timescale 1ns/100ps
`include "pipe_defs.svh"

module mem_access (
    input  logic                clk,
    input  logic                i_en,
    input  logic                i_mem_read,
    input  logic                i_mem_write,
    input  logic                i_branch,
    input  logic                i_jump,
    input  ctrl_pkg::mem_size_t i_data_size,   // Also set by decode for loads
    input  data_pkg::word_t     i_alu,         // Byte address or branch compare
    input  data_pkg::word_t     i_data2,
    input  data_pkg::pc_t       i_branch_addr,
    output logic                o_redirect,
    output data_pkg::pc_t       o_redirect_pc,
    output data_pkg::word_t     o_rd_data
);

    import ctrl_pkg::*;
    import data_pkg::*;

    byte_en_t                        be;
    word_t                           wdata;
    logic [`PIPE_DMEM_WORDS_LOG2-1:0] word_addr;
    logic                            we;
    logic                            re;

    // Lane strobes from size and low address bits
    always_comb begin
        case (i_data_size)
            SIZE_BYTE: begin
                be    = 4'b0001 << i_alu[1:0];
                wdata = {4{i_data2[7:0]}};   // Byte copied to every lane
            end
            SIZE_HALF: begin
                be    = 4'b0011 << {i_alu[1], 1'b0};
                wdata = {2{i_data2[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = i_data2;
            end
        endcase
    end

    assign word_addr = i_alu[`PIPE_DMEM_WORDS_LOG2+1:2];

    // Stalled cycles must not repeat a store or reload the read register
    assign we = i_mem_write & i_en;
    assign re = i_mem_read & i_en;

    // Taken branch result sits in ALU bit 0
    assign o_redirect    = i_jump | (i_branch & i_alu[0]);
    assign o_redirect_pc = i_branch_addr;

    data_mem data_mem_i (
        .clk     (clk),
        .i_we    (we),
        .i_re    (re),
        .i_addr  (word_addr),
        .i_be    (be),
        .i_wdata (wdata),
        .o_rdata (o_rd_data)
    );

    a_half_align: assert property (@(posedge clk)
        (we || re) && i_data_size == SIZE_HALF |-> !i_alu[0])
        else $error("mem_access: half-word access at odd address");

    a_word_align: assert property (@(posedge clk)
        (we || re) && i_data_size == SIZE_WORD |-> i_alu[1:0] == 2'b00)
        else $error("mem_access: word access not 4-byte aligned");

endmodule

/* src/mem_wb_reg.sv */
/*
 * MEM/WB pipeline register
 * Carries write-back control, ALU result, link address and load format
 */
`timescale 1ns/100ps

module mem_wb_reg (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_en,
    input  logic                i_reg_write,
    input  logic                i_mem_to_reg,
    input  logic                i_link_reg,
    input  ctrl_pkg::reg_addr_t i_rd_addr,
    input  ctrl_pkg::func3_t    i_func3,       // Load size and sign
    input  data_pkg::word_t     i_alu,         // Low bits locate the load lanes
    input  data_pkg::pc_t       i_pc_next,
    output logic                o_reg_write,
    output logic                o_mem_to_reg,
    output logic                o_link_reg,
    output ctrl_pkg::reg_addr_t o_rd_addr,
    output ctrl_pkg::func3_t    o_func3,
    output data_pkg::word_t     o_alu,
    output data_pkg::pc_t       o_pc_next
);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_reg_write  <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_link_reg   <= 1'b0;
            o_func3      <= '0;
        end else if (i_en) begin
            o_reg_write  <= i_reg_write;
            o_mem_to_reg <= i_mem_to_reg;
            o_link_reg   <= i_link_reg;
            o_func3      <= i_func3;
        end
    end

    // Payload, held on stall
    always_ff @(posedge clk) begin
        if (i_en) begin
            o_rd_addr <= i_rd_addr;
            o_alu     <= i_alu;
            o_pc_next <= i_pc_next;
        end
    end

endmodule

/* src/mem_wb_top.sv */
/*
 * Memory and write-back stages of the RV32I pipeline
 * EX/MEM register, data memory access, MEM/WB register, write-back mux
 */
`timescale 1ns/100ps

module mem_wb_top (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_en,          // Stage enable from hazard unit
    input  logic                i_flush,
    input  logic                i_reg_write,
    input  logic                i_mem_read,
    input  logic                i_mem_write,
    input  logic                i_mem_to_reg,
    input  logic                i_branch,
    input  logic                i_jump,
    input  logic                i_link_reg,
    input  ctrl_pkg::mem_size_t i_data_size,
    input  ctrl_pkg::func3_t    i_func3,
    input  ctrl_pkg::reg_addr_t i_rd_addr,
    input  data_pkg::pc_t       i_pc_next,
    input  data_pkg::pc_t       i_branch_addr,
    input  data_pkg::word_t     i_alu,
    input  data_pkg::word_t     i_data2,
    output logic                o_redirect,
    output data_pkg::pc_t       o_redirect_pc,
    output logic                o_wb_en,
    output ctrl_pkg::reg_addr_t o_wb_rd,
    output data_pkg::word_t     o_wb_data
);

    import ctrl_pkg::*;
    import data_pkg::*;

    // EX/MEM outputs
    logic      em_reg_write;
    logic      em_mem_read;
    logic      em_mem_write;
    logic      em_mem_to_reg;
    logic      em_branch;
    logic      em_jump;
    logic      em_link_reg;
    mem_size_t em_data_size;
    func3_t    em_func3;
    reg_addr_t em_rd_addr;
    pc_t       em_pc_next;
    pc_t       em_branch_addr;
    word_t     em_alu;
    word_t     em_data2;

    word_t     rd_data;

    // MEM/WB outputs
    logic      wb_reg_write;
    logic      wb_mem_to_reg;
    logic      wb_link_reg;
    reg_addr_t wb_rd_addr;
    func3_t    wb_func3;
    word_t     wb_alu;
    pc_t       wb_pc_next;

    ex_mem_reg ex_mem_reg_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_en          (i_en),
        .i_flush       (i_flush),
        .i_reg_write   (i_reg_write),
        .i_mem_read    (i_mem_read),
        .i_mem_write   (i_mem_write),
        .i_mem_to_reg  (i_mem_to_reg),
        .i_branch      (i_branch),
        .i_jump        (i_jump),
        .i_link_reg    (i_link_reg),
        .i_data_size   (i_data_size),
        .i_func3       (i_func3),
        .i_rd_addr     (i_rd_addr),
        .i_pc_next     (i_pc_next),
        .i_branch_addr (i_branch_addr),
        .i_alu         (i_alu),
        .i_data2       (i_data2),
        .o_reg_write   (em_reg_write),
        .o_mem_read    (em_mem_read),
        .o_mem_write   (em_mem_write),
        .o_mem_to_reg  (em_mem_to_reg),
        .o_branch      (em_branch),
        .o_jump        (em_jump),
        .o_link_reg    (em_link_reg),
        .o_data_size   (em_data_size),
        .o_func3       (em_func3),
        .o_rd_addr     (em_rd_addr),
        .o_pc_next     (em_pc_next),
        .o_branch_addr (em_branch_addr),
        .o_alu         (em_alu),
        .o_data2       (em_data2)
    );

    mem_access mem_access_i (
        .clk           (clk),
        .i_en          (i_en),
        .i_mem_read    (em_mem_read),
        .i_mem_write   (em_mem_write),
        .i_branch      (em_branch),
        .i_jump        (em_jump),
        .i_data_size   (em_data_size),
        .i_alu         (em_alu),
        .i_data2       (em_data2),
        .i_branch_addr (em_branch_addr),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_rd_data     (rd_data)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_reg_write  (em_reg_write),
        .i_mem_to_reg (em_mem_to_reg),
        .i_link_reg   (em_link_reg),
        .i_rd_addr    (em_rd_addr),
        .i_func3      (em_func3),
        .i_alu        (em_alu),
        .i_pc_next    (em_pc_next),
        .o_reg_write  (wb_reg_write),
        .o_mem_to_reg (wb_mem_to_reg),
        .o_link_reg   (wb_link_reg),
        .o_rd_addr    (wb_rd_addr),
        .o_func3      (wb_func3),
        .o_alu        (wb_alu),
        .o_pc_next    (wb_pc_next)
    );

    writeback_sel writeback_sel_i (
        .i_reg_write  (wb_reg_write),
        .i_mem_to_reg (wb_mem_to_reg),
        .i_link_reg   (wb_link_reg),
        .i_rd_addr    (wb_rd_addr),
        .i_func3      (wb_func3),
        .i_alu        (wb_alu),
        .i_pc_next    (wb_pc_next),
        .i_rd_data    (rd_data),
        .o_wb_en      (o_wb_en),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

endmodule

/* src/pipe_defs.svh */
/*
 * Pipeline widths and sizes
 * Shared by the memory and write-back stages and their packages
 */
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// PC width
`define PIPE_NB_PC 32

// Data word width
`define PIPE_DATA_WIDTH 32

// Register file address width
`define PIPE_NB_REG 5

// Data memory holds 2**8 words
`define PIPE_DMEM_WORDS_LOG2 8

`endif

/* src/writeback_sel.sv */
/*
 * Write-back select
 * Extracts and extends load data, then picks the value for the
 * register file. Register 0 is never written
 */
`timescale 1ns/100ps

module writeback_sel (
    input  logic                i_reg_write,
    input  logic                i_mem_to_reg,
    input  logic                i_link_reg,
    input  ctrl_pkg::reg_addr_t i_rd_addr,
    input  ctrl_pkg::func3_t    i_func3,
    input  data_pkg::word_t     i_alu,
    input  data_pkg::pc_t       i_pc_next,
    input  data_pkg::word_t     i_rd_data,     // Registered RAM word
    output logic                o_wb_en,
    output ctrl_pkg::reg_addr_t o_wb_rd,
    output data_pkg::word_t     o_wb_data
);

    import ctrl_pkg::*;
    import data_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        ld_unsigned;
    word_t       ld_ext;

    assign ld_byte     = i_rd_data[{i_alu[1:0], 3'b000} +: 8];
    assign ld_half     = i_alu[1] ? i_rd_data[31:16] : i_rd_data[15:0];
    assign ld_unsigned = i_func3[2];   // LBU, LHU

    always_comb begin
        case (mem_size_t'(i_func3[1:0]))
            SIZE_BYTE: begin
                ld_ext = ld_unsigned ? {24'b0, ld_byte} : {{24{ld_byte[7]}}, ld_byte};
            end
            SIZE_HALF: begin
                ld_ext = ld_unsigned ? {16'b0, ld_half} : {{16{ld_half[15]}}, ld_half};
            end
            default: ld_ext = i_rd_data;
        endcase
    end

    // Link beats load beats ALU
    always_comb begin
        if (i_link_reg) begin
            o_wb_data = i_pc_next;
        end else if (i_mem_to_reg) begin
            o_wb_data = ld_ext;
        end else begin
            o_wb_data = i_alu;
        end
    end

    assign o_wb_en = i_reg_write & (|i_rd_addr);   // x0 stays zero
    assign o_wb_rd = i_rd_addr;

endmodule

/* verif/mem_wb_tb.sv */
/*
 * Testbench for the memory and write-back stages
 * Random ALU, link, branch, load and store traffic with stalls and flushes,
 * checked against a byte-level memory model and a write-back queue
 */
`timescale 1ns/100ps
`include "pipe_defs.svh"

module mem_wb_tb;

    import ctrl_pkg::*;
    import data_pkg::*;

    localparam int unsigned RAND_SEED = 32'hef5a_289c;

    // Instruction kinds presented to EX/MEM
    localparam int K_BUBBLE = 0;
    localparam int K_ALU    = 1;
    localparam int K_STORE  = 2;
    localparam int K_LOAD   = 3;

    localparam int BYTE_AW = `PIPE_DMEM_WORDS_LOG2 + 2;
    localparam int N_WORDS = 2 ** `PIPE_DMEM_WORDS_LOG2;
    localparam int N_RESET = 5;
    localparam int N_IDLE  = 4;
    localparam int N_ALU   = 200;
    localparam int N_MEM   = 100;   // One store and five loads each
    localparam int N_MIX   = 400;
    localparam int N_DRAIN = 4;
    localparam int TOTAL_CYCLES = N_RESET + N_IDLE + N_WORDS + N_ALU + 6 * N_MEM
                                + N_MIX + N_DRAIN;
    localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES + 50;

    typedef logic [BYTE_AW-1:0] baddr_t;

    typedef struct packed {
        logic      real_op;   // Not a bubble, data and rd are checked
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } wb_exp_t;

    logic      clk = 1'b0;
    logic      i_rst_n;
    logic      i_en;
    logic      i_flush;
    logic      i_reg_write;
    logic      i_mem_read;
    logic      i_mem_write;
    logic      i_mem_to_reg;
    logic      i_branch;
    logic      i_jump;
    logic      i_link_reg;
    mem_size_t i_data_size;
    func3_t    i_func3;
    reg_addr_t i_rd_addr;
    pc_t       i_pc_next;
    pc_t       i_branch_addr;
    word_t     i_alu;
    word_t     i_data2;
    logic      o_redirect;
    pc_t       o_redirect_pc;
    logic      o_wb_en;
    reg_addr_t o_wb_rd;
    word_t     o_wb_data;

    // Reference model state
    logic [7:0]  mem_model [2 ** BYTE_AW];
    wb_exp_t     wb_q [$];   // [0] in MEM/WB, [1] in EX/MEM
    logic        em_real;
    logic        em_store;
    logic        em_redirect;
    pc_t         em_pc;
    int unsigned em_addr;
    mem_size_t   em_size;
    word_t       em_wdata;

    string       test_name;
    int          cycle_cnt = 0;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles in %s", CYCLE_LIMIT, test_name);
            $display("tests failed");
            $fatal(1, "Simulation timeout");
        end
    end

    mem_wb_top dut_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_en          (i_en),
        .i_flush       (i_flush),
        .i_reg_write   (i_reg_write),
        .i_mem_read    (i_mem_read),
        .i_mem_write   (i_mem_write),
        .i_mem_to_reg  (i_mem_to_reg),
        .i_branch      (i_branch),
        .i_jump        (i_jump),
        .i_link_reg    (i_link_reg),
        .i_data_size   (i_data_size),
        .i_func3       (i_func3),
        .i_rd_addr     (i_rd_addr),
        .i_pc_next     (i_pc_next),
        .i_branch_addr (i_branch_addr),
        .i_alu         (i_alu),
        .i_data2       (i_data2),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_wb_en       (o_wb_en),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, name, expected, actual);
            $display("tests failed");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, name, expected, actual);
            $display("tests failed");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %b, actual %b", test_name, name, expected, actual);
            $display("tests failed");
            $fatal(1, "Bit mismatch");
        end
    endtask

    // Little-endian bytes, size from the store's funct3 bits 1:0
    task automatic store_bytes(input int unsigned addr, input mem_size_t size, input word_t data);
        int n;
        n = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
        for (int k = 0; k < n; k++) begin
            mem_model[baddr_t'(addr + k)] = data[8*k +: 8];
        end
    endtask

    function automatic word_t load_value(input int unsigned addr, input func3_t f3);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = mem_model[baddr_t'(addr)];
        b1 = mem_model[baddr_t'(addr + 1)];
        b2 = mem_model[baddr_t'(addr + 2)];
        b3 = mem_model[baddr_t'(addr + 3)];
        case (f3)
            3'b000:  return {{24{b0[7]}}, b0};   // LB
            3'b100:  return {24'd0, b0};          // LBU
            3'b001:  return {{16{b1[7]}}, b1, b0};
            3'b101:  return {16'd0, b1, b0};
            default: return {b3, b2, b1, b0};     // LW
        endcase
    endfunction

    // Random aligned byte offset inside a word
    function automatic int unsigned lane_offset(input func3_t f3);
        case (f3[1:0])
            2'd0:    return $urandom_range(3);
            2'd1:    return 2 * $urandom_range(1);
            default: return 0;
        endcase
    endfunction

    function automatic func3_t load_f3(input int idx);
        case (idx)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b010;
            3:       return 3'b100;
            default: return 3'b101;
        endcase
    endfunction

    task automatic check_outputs();
        wb_exp_t head;
        head = wb_q[0];
        check_bit("wb_en", head.en, o_wb_en);
        if (head.real_op) begin
            check_reg("wb_rd", head.rd, o_wb_rd);
            check_word("wb_data", head.data, o_wb_data);
        end
        check_bit("redirect", em_redirect, o_redirect);
        if (em_real) begin
            check_word("redirect_pc", em_pc, o_redirect_pc);
        end
    endtask

    // One cycle: check, drive on the falling edge, advance the model
    task automatic issue(input int kind, input int unsigned widx, input func3_t f3,
                         input logic en, input logic flush);
        int unsigned addr;
        wb_exp_t     ent;
        @(negedge clk);
        check_outputs();
        addr = 4 * widx + lane_offset(f3);

        i_reg_write   = 1'b0;
        i_mem_read    = 1'b0;
        i_mem_write   = 1'b0;
        i_mem_to_reg  = 1'b0;
        i_branch      = 1'b0;
        i_jump        = 1'b0;
        i_link_reg    = 1'b0;
        i_data_size   = f3[1:0];
        i_func3       = f3;
        i_rd_addr     = reg_addr_t'($urandom);
        i_pc_next     = $urandom;
        i_branch_addr = $urandom;
        i_alu         = $urandom;
        i_data2       = $urandom;
        case (kind)
            K_ALU: begin
                i_reg_write = ($urandom_range(3) != 0);
                i_branch    = ($urandom_range(3) == 0);
                i_jump      = ($urandom_range(5) == 0);
                i_link_reg  = i_jump || ($urandom_range(7) == 0);
                if ($urandom_range(7) == 0) begin
                    i_rd_addr = '0;   // x0 target
                end
            end
            K_STORE: begin
                i_mem_write = 1'b1;
                i_alu       = addr;
            end
            K_LOAD: begin
                i_mem_read   = 1'b1;
                i_mem_to_reg = 1'b1;
                i_reg_write  = 1'b1;
                i_alu        = addr;
            end
            default: ;
        endcase
        i_en    = en;
        i_flush = flush;

        if (en) begin
            if (em_store) begin
                store_bytes(em_addr, em_size, em_wdata);   // Leaves EX/MEM at this edge
            end
            wb_q.delete(0);
            ent         = '0;
            em_real     = 1'b0;
            em_store    = 1'b0;
            em_redirect = 1'b0;
            if (!flush && kind != K_BUBBLE) begin
                ent.real_op = 1'b1;
                ent.en      = i_reg_write && (i_rd_addr != '0);
                ent.rd      = i_rd_addr;
                if (i_link_reg) begin
                    ent.data = i_pc_next;
                end else if (kind == K_LOAD) begin
                    ent.data = load_value(addr, f3);
                end else begin
                    ent.data = i_alu;
                end
                em_real     = 1'b1;
                em_store    = (kind == K_STORE);
                em_addr     = addr;
                em_size     = f3[1:0];
                em_wdata    = i_data2;
                em_redirect = i_jump || (i_branch && i_alu[0]);
                em_pc       = i_branch_addr;
            end
            wb_q.push_back(ent);
        end
    endtask

    initial begin
        wb_exp_t idle_ent;
        int      w;
        int      kind;
        logic    mix_en;
        logic    mix_flush;
        func3_t  f3;

        void'($urandom(RAND_SEED));
        i_rst_n       = 1'b0;
        i_en          = 1'b0;
        i_flush       = 1'b0;
        i_reg_write   = 1'b0;
        i_mem_read    = 1'b0;
        i_mem_write   = 1'b0;
        i_mem_to_reg  = 1'b0;
        i_branch      = 1'b0;
        i_jump        = 1'b0;
        i_link_reg    = 1'b0;
        i_data_size   = '0;
        i_func3       = '0;
        i_rd_addr     = '0;
        i_pc_next     = '0;
        i_branch_addr = '0;
        i_alu         = '0;
        i_data2       = '0;
        em_real       = 1'b0;
        em_store      = 1'b0;
        em_redirect   = 1'b0;
        idle_ent      = '0;
        wb_q.push_back(idle_ent);
        wb_q.push_back(idle_ent);

        test_name = "reset";
        repeat (N_RESET) @(negedge clk);
        i_rst_n = 1'b1;

        test_name = "reset_idle";   // Stalled, nothing may reach the outputs
        for (int i = 0; i < N_IDLE; i++) begin
            issue(K_ALU, 0, 3'd0, 1'b0, 1'b0);
        end

        test_name = "fill";
        for (int i = 0; i < N_WORDS; i++) begin
            issue(K_STORE, i, 3'b010, 1'b1, 1'b0);
        end

        test_name = "alu_link_branch";
        for (int i = 0; i < N_ALU; i++) begin
            issue(K_ALU, 0, 3'd0, 1'b1, 1'b0);
        end

        test_name = "store_load";
        for (int i = 0; i < N_MEM; i++) begin
            w = $urandom_range(N_WORDS - 1);
            issue(K_STORE, w, func3_t'($urandom_range(2)), 1'b1, 1'b0);
            for (int j = 0; j < 5; j++) begin
                issue(K_LOAD, w, load_f3(j), 1'b1, 1'b0);
            end
        end

        // Few words so loads revisit flushed and stalled stores
        test_name = "flush_stall";
        for (int i = 0; i < N_MIX; i++) begin
            kind      = $urandom_range(3);
            mix_en    = ($urandom_range(3) != 0);
            mix_flush = mix_en && ($urandom_range(7) == 0);
            f3 = (kind == K_LOAD) ? load_f3($urandom_range(4)) : func3_t'($urandom_range(2));
            issue(kind, $urandom_range(7), f3, mix_en, mix_flush);
        end

        test_name = "drain";
        repeat (N_DRAIN - 1) issue(K_BUBBLE, 0, 3'd0, 1'b1, 1'b0);
        @(negedge clk);
        check_outputs();

        $display("all tests passed");
        $finish;
    end

endmodule
